// ==== kvs_pkg.sv ====
/*
 * kvs_pkg
 * Types on the key-value store side of the egress path: session ids,
 * response metadata and the response beat as it leaves the store.
 */
package kvs_pkg;

   // ----------------------------------------------------------
   // scalar types
   // ----------------------------------------------------------

   // connection session id, low 16 bits of the response metadata
   typedef logic [15:0] session_id_t;

   // response metadata word
   typedef logic [63:0] kvs_meta_t;

   // response payload word as produced by the store
   typedef logic [63:0] kvs_word_t;

   // ----------------------------------------------------------
   // response beat
   // ----------------------------------------------------------

   // last sits on top, then metadata, then data in the low 64 bits
   typedef struct packed {
      logic      last;
      kvs_meta_t meta;
      kvs_word_t data;
   } kvs_beat_t;

endpackage

// ==== net_pkg.sv ====
/*
 * net_pkg
 * Types on the network side: transmit data beats, transmit metadata
 * words and listen port numbers.
 */
package net_pkg;

   import kvs_pkg::*;

   // ----------------------------------------------------------
   // scalar types
   // ----------------------------------------------------------

   // one transmit data word
   typedef logic [63:0] net_word_t;

   // tcp port number
   typedef logic [15:0] port_t;

   // message length in bytes
   typedef logic [15:0] byte_len_t;

   // every transmit beat carries a full word
   localparam byte_len_t BEAT_BYTES = 16'd8;

   // ----------------------------------------------------------
   // stream words
   // ----------------------------------------------------------

   typedef struct packed {
      logic      last;
      net_word_t data;
   } tx_beat_t;

   // length in the upper half, session in the lower half
   typedef struct packed {
      byte_len_t   len;
      session_id_t session;
   } tx_meta_t;

endpackage

// ==== stream_fifo.sv ====
`timescale 1ns/100ps

/*
 * stream_fifo
 * Valid/ready FIFO over a register array for a packed word of any width.
 * Holds 2**ADDR_BITS words. A word written into an empty FIFO shows at
 * the output on the following cycle; ready is high while there is room.
 */
module stream_fifo #(
   parameter int unsigned WIDTH     = 64,
   parameter int unsigned ADDR_BITS = 4
) (
   input  logic             aclk,
   input  logic             aresetn,
   input  logic             in_valid,
   output logic             in_ready,
   input  logic [WIDTH-1:0] in_data,
   output logic             out_valid,
   input  logic             out_ready,
   output logic [WIDTH-1:0] out_data
);

   localparam int unsigned        DEPTH      = 2 ** ADDR_BITS;
   localparam logic [ADDR_BITS:0] FULL_COUNT = (ADDR_BITS + 1)'(DEPTH);

   logic [WIDTH-1:0]     mem [DEPTH];
   logic [ADDR_BITS-1:0] wr_ptr;
   logic [ADDR_BITS-1:0] rd_ptr;
   logic [ADDR_BITS:0]   count;
   logic [ADDR_BITS:0]   count_next;
   logic                 push;
   logic                 pop;

   assign in_ready = (count != FULL_COUNT);
   assign push     = in_valid && in_ready;
   assign pop      = out_valid && out_ready;

   // head of the queue is read straight from the array
   assign out_data = mem[rd_ptr];

   always_comb begin
      count_next = count;
      if (push && !pop) begin
         count_next = count + 1'b1;
      end else if (pop && !push) begin
         count_next = count - 1'b1;
      end
   end

   always_ff @(posedge aclk) begin
      if (push) begin
         mem[wr_ptr] <= in_data;
      end
   end

   // ----------------------------------------------------------
   // pointers, occupancy and output valid
   // ----------------------------------------------------------
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         out_valid <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count_next;
         // valid follows the occupancy of the next cycle
         out_valid <= (count_next != '0);
      end
   end

endmodule

// ==== listen_port_opener.sv ====
`timescale 1ns/100ps

/*
 * listen_port_opener
 * After reset, announces PORT_COUNT consecutive listen ports starting at
 * FIRST_PORT. Each port is a single-cycle pulse; a new one is raised
 * only after an idle cycle in which the network side showed ready.
 */
module listen_port_opener
   import net_pkg::*;
#(
   parameter int unsigned FIRST_PORT = 2880,
   parameter int unsigned PORT_COUNT = 8
) (
   input  logic  aclk,
   input  logic  aresetn,
   output logic  port_valid,
   input  logic  port_ready,
   output port_t port
);

   localparam int unsigned PW = $bits(port_t);

   // one bit wider than a port so the end of the range always fits
   localparam logic [PW:0] START_PORT = (PW + 1)'(FIRST_PORT);
   localparam logic [PW:0] END_PORT   = (PW + 1)'(FIRST_PORT + PORT_COUNT);

   logic [PW:0] next_port;
   logic        fire;

   // no pulse last cycle, ready seen, ports left
   assign fire = !port_valid && port_ready && (next_port < END_PORT);

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         next_port  <= START_PORT;
         port_valid <= 1'b0;
      end else begin
         // pulse lasts exactly one cycle
         port_valid <= fire;
         if (fire) begin
            next_port <= next_port + 1'b1;
         end
      end
   end

   always_ff @(posedge aclk) begin
      if (fire) begin
         port <= port_t'(next_port[PW-1:0]);
      end
   end

endmodule

// ==== response_framer.sv ====
`timescale 1ns/100ps

/*
 * response_framer
 * Forwards response beats from the key-value store as transmit beats,
 * appends a zero-data trailer beat after each response and builds one
 * transmit metadata word (byte length and session) per message, where
 * a message is either a response or its trailer.
 */
module response_framer
   import kvs_pkg::*;
   import net_pkg::*;
(
   input  logic      aclk,
   input  logic      aresetn,

   input  logic      in_valid,
   output logic      in_ready,
   input  kvs_beat_t in_beat,

   output logic      out_valid,
   input  logic      out_ready,
   output tx_beat_t  out_beat,

   output logic      meta_valid,
   input  logic      meta_ready,
   output tx_meta_t  meta
);

   typedef enum logic {
      PASS,
      TRAILER
   } state_t;

   state_t      state;
   logic        first_beat;
   byte_len_t   byte_cnt;
   session_id_t cur_session;
   session_id_t trailer_session;

   logic        meta_stall;
   logic        out_fire;
   session_id_t beat_session;
   byte_len_t   len_now;
   session_id_t sess_now;

   // ----------------------------------------------------------
   // beat selection and handshakes
   // ----------------------------------------------------------

   // a finished word that cannot enter its FIFO blocks the next last beat,
   // so every beat is held back until it drains
   assign meta_stall = meta_valid && !meta_ready;

   always_comb begin
      case (state)
         TRAILER: begin
            out_valid     = !meta_stall;
            out_beat.last = 1'b1;
            out_beat.data = '0;
            in_ready      = 1'b0;
            beat_session  = trailer_session;
         end
         default: begin
            out_valid     = in_valid && !meta_stall;
            out_beat.last = in_beat.last;
            out_beat.data = in_beat.data;
            in_ready      = out_ready && !meta_stall;
            beat_session  = in_beat.meta[15:0];
         end
      endcase
   end

   assign out_fire = out_valid && out_ready;

   // running length and session including the beat on the output now
   assign len_now  = first_beat ? BEAT_BYTES : byte_len_t'(byte_cnt + BEAT_BYTES);
   assign sess_now = first_beat ? beat_session : cur_session;

   // ----------------------------------------------------------
   // control state
   // ----------------------------------------------------------
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         state      <= PASS;
         first_beat <= 1'b1;
         meta_valid <= 1'b0;
      end else begin
         if (out_fire) begin
            // next beat starts a new message after any last beat
            first_beat <= out_beat.last;
            case (state)
               PASS: begin
                  if (out_beat.last) begin
                     state <= TRAILER;
                  end
               end
               default: begin
                  state <= PASS;
               end
            endcase
         end

         if (out_fire && out_beat.last) begin
            meta_valid <= 1'b1;
         end else if (meta_valid && meta_ready) begin
            meta_valid <= 1'b0;
         end
      end
   end

   // ----------------------------------------------------------
   // length, session and metadata word
   // ----------------------------------------------------------
   always_ff @(posedge aclk) begin
      if (out_fire) begin
         byte_cnt <= len_now;
         if (first_beat) begin
            cur_session <= beat_session;
         end
         // trailer takes its session from the response's final metadata
         if (state == PASS && out_beat.last) begin
            trailer_session <= in_beat.meta[15:0];
         end
         if (out_beat.last) begin
            meta.len     <= len_now;
            meta.session <= sess_now;
         end
      end
   end

endmodule

// ==== kvs_net_egress.sv ====
`timescale 1ns/100ps

/*
 * kvs_net_egress
 * Network egress of the key-value store. Opens the listen ports after
 * reset and turns store responses into transmit data beats plus one
 * metadata word per message, both buffered in FIFOs.
 */
module kvs_net_egress
   import kvs_pkg::*;
   import net_pkg::*;
#(
   parameter int unsigned FIRST_PORT          = 2880,
   parameter int unsigned PORT_COUNT          = 8,
   parameter int unsigned DATA_FIFO_ADDR_BITS = 9,
   parameter int unsigned META_FIFO_ADDR_BITS = 4
) (
   input  logic      aclk,
   input  logic      aresetn,

   // responses from the store
   input  logic      resp_valid,
   output logic      resp_ready,
   input  kvs_beat_t resp_beat,

   // transmit data
   output logic      tx_data_valid,
   input  logic      tx_data_ready,
   output tx_beat_t  tx_data,

   // transmit metadata
   output logic      tx_meta_valid,
   input  logic      tx_meta_ready,
   output tx_meta_t  tx_meta,

   // listen port pulses
   output logic      listen_port_valid,
   input  logic      listen_port_ready,
   output port_t     listen_port
);

   logic     fr_data_valid;
   logic     fr_data_ready;
   tx_beat_t fr_data;
   logic     fr_meta_valid;
   logic     fr_meta_ready;
   tx_meta_t fr_meta;

   // ----------------------------------------------------------
   // listen ports
   // ----------------------------------------------------------
   listen_port_opener #(
      .FIRST_PORT (FIRST_PORT),
      .PORT_COUNT (PORT_COUNT)
   ) u_port_opener (
      .aclk       (aclk),
      .aresetn    (aresetn),
      .port_valid (listen_port_valid),
      .port_ready (listen_port_ready),
      .port       (listen_port)
   );

   // ----------------------------------------------------------
   // response framing
   // ----------------------------------------------------------
   response_framer u_framer (
      .aclk       (aclk),
      .aresetn    (aresetn),
      .in_valid   (resp_valid),
      .in_ready   (resp_ready),
      .in_beat    (resp_beat),
      .out_valid  (fr_data_valid),
      .out_ready  (fr_data_ready),
      .out_beat   (fr_data),
      .meta_valid (fr_meta_valid),
      .meta_ready (fr_meta_ready),
      .meta       (fr_meta)
   );

   // ----------------------------------------------------------
   // output buffering
   // ----------------------------------------------------------
   stream_fifo #(
      .WIDTH     ($bits(tx_beat_t)),
      .ADDR_BITS (DATA_FIFO_ADDR_BITS)
   ) u_data_fifo (
      .aclk      (aclk),
      .aresetn   (aresetn),
      .in_valid  (fr_data_valid),
      .in_ready  (fr_data_ready),
      .in_data   (fr_data),
      .out_valid (tx_data_valid),
      .out_ready (tx_data_ready),
      .out_data  (tx_data)
   );

   stream_fifo #(
      .WIDTH     ($bits(tx_meta_t)),
      .ADDR_BITS (META_FIFO_ADDR_BITS)
   ) u_meta_fifo (
      .aclk      (aclk),
      .aresetn   (aresetn),
      .in_valid  (fr_meta_valid),
      .in_ready  (fr_meta_ready),
      .in_data   (fr_meta),
      .out_valid (tx_meta_valid),
      .out_ready (tx_meta_ready),
      .out_data  (tx_meta)
   );

endmodule

// ==== tb_checks.svh ====
/*
 * testbench checks
 * Typed compare tasks for the egress outputs, error reporting and the
 * check counters shared by the monitors and the main sequence.
 */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int pass_cnt   = 0;
int fail_cnt   = 0;
int beat_errs  = 0;
int meta_errs  = 0;
int port_errs  = 0;
int other_errs = 0;

task automatic report_problem(input string msg);
   fail_cnt++;
   $display("ERROR: %s at %0t", msg, $time);
endtask

task automatic check_beat(input string name, input tx_beat_t exp, input tx_beat_t act);
   if (act !== exp) begin
      beat_errs++;
      fail_cnt++;
      $display("FAIL %s: expected last=%0b data=%h, actual last=%0b data=%h",
               name, exp.last, exp.data, act.last, act.data);
   end else begin
      pass_cnt++;
   end
endtask

task automatic check_meta(input string name, input tx_meta_t exp, input tx_meta_t act);
   if (act !== exp) begin
      meta_errs++;
      fail_cnt++;
      $display("FAIL %s: expected len=%0d session=%h, actual len=%0d session=%h",
               name, exp.len, exp.session, act.len, act.session);
   end else begin
      pass_cnt++;
   end
endtask

task automatic check_port(input string name, input port_t exp, input port_t act);
   if (act !== exp) begin
      port_errs++;
      fail_cnt++;
      $display("FAIL %s: expected port=%0d, actual port=%0d", name, exp, act);
   end else begin
      pass_cnt++;
   end
endtask

// one line per finished test
task automatic report_test(input string name, input int errs);
   $display("test %-18s %s (%0d errors)", name, (errs == 0) ? "passed" : "failed", errs);
endtask

`endif

// ==== tb_kvs_net_egress.sv ====
`timescale 1ns/100ps

/*
 * tb_kvs_net_egress
 * Testbench for the key-value store network egress. Drives random
 * responses and ready patterns, checks the transmit streams and the
 * listen port pulses against a queue-based model.
 */
module tb_kvs_net_egress
   import kvs_pkg::*;
   import net_pkg::*;
();

   localparam int unsigned FIRST_PORT = 2880;
   localparam int unsigned PORT_COUNT = 8;
   localparam int unsigned PHASE1     = 10;
   localparam int unsigned PHASE2     = 50;
   localparam int unsigned MAX_LEN    = 6;
   // 20 cycles per possible beat, trailers included, plus slack
   localparam int unsigned WATCHDOG_CYCLES = 20 * (PHASE1 + PHASE2) * (MAX_LEN + 1) + 200;

   logic      aclk;
   logic      aresetn;
   logic      resp_valid;
   logic      resp_ready;
   kvs_beat_t resp_beat;
   logic      tx_data_valid;
   logic      tx_data_ready;
   tx_beat_t  tx_data;
   logic      tx_meta_valid;
   logic      tx_meta_ready;
   tx_meta_t  tx_meta;
   logic      listen_port_valid;
   logic      listen_port_ready;
   port_t     listen_port;

   kvs_beat_t stim_q[$];
   tx_beat_t  exp_beats[$];
   tx_meta_t  exp_metas[$];
   string     data_test;
   string     meta_test;
   int        port_idx  = 0;
   logic      port_prev = 1'b0;
   logic      random_ready;
   int        data_hold = 0;
   int        meta_hold = 0;

   `include "tb_checks.svh"

   kvs_net_egress #(
      .FIRST_PORT          (FIRST_PORT),
      .PORT_COUNT          (PORT_COUNT),
      .DATA_FIFO_ADDR_BITS (3),
      .META_FIFO_ADDR_BITS (2)
   ) u_dut (
      .aclk              (aclk),
      .aresetn           (aresetn),
      .resp_valid        (resp_valid),
      .resp_ready        (resp_ready),
      .resp_beat         (resp_beat),
      .tx_data_valid     (tx_data_valid),
      .tx_data_ready     (tx_data_ready),
      .tx_data           (tx_data),
      .tx_meta_valid     (tx_meta_valid),
      .tx_meta_ready     (tx_meta_ready),
      .tx_meta           (tx_meta),
      .listen_port_valid (listen_port_valid),
      .listen_port_ready (listen_port_ready),
      .listen_port       (listen_port)
   );

   initial aclk = 1'b0;
   always #5 aclk = ~aclk;

   // ----------------------------------------------------------
   // model and stimulus
   // ----------------------------------------------------------

   // a response gives its beats, a zero trailer and two metadata words
   task automatic add_response();
      int unsigned n;
      kvs_beat_t   b;
      session_id_t first_sess;
      tx_beat_t    eb;
      tx_meta_t    em;
      n = $urandom_range(1, MAX_LEN);
      for (int i = 0; i < n; i++) begin
         b.last = (i == n - 1);
         b.meta = {$urandom, $urandom};
         b.data = {$urandom, $urandom};
         if (i == 0) begin
            first_sess = b.meta[15:0];
         end
         stim_q.push_back(b);
         eb.last = b.last;
         eb.data = b.data;
         exp_beats.push_back(eb);
      end
      eb.last = 1'b1;
      eb.data = '0;
      exp_beats.push_back(eb);
      em.len     = 16'(8 * n);
      em.session = first_sess;
      exp_metas.push_back(em);
      // trailer word, session from the final beat's metadata
      em.len     = 16'd8;
      em.session = b.meta[15:0];
      exp_metas.push_back(em);
   endtask

   // called 1 ns after a rising edge, returns at the same point
   task automatic drive_responses();
      kvs_beat_t b;
      while (stim_q.size() > 0) begin
         b          = stim_q.pop_front();
         resp_valid = 1'b1;
         resp_beat  = b;
         do @(posedge aclk); while (!resp_ready);
         #1;
      end
      resp_valid = 1'b0;
   endtask

   // queues are looked at once the monitors are done with the edge
   task automatic wait_drained();
      do begin
         @(posedge aclk);
         #1;
      end while (exp_beats.size() != 0 || exp_metas.size() != 0);
   endtask

   task automatic check_idle(input string when);
      if (tx_data_valid !== 1'b0 || tx_meta_valid !== 1'b0 || listen_port_valid !== 1'b0) begin
         other_errs++;
         report_problem($sformatf("an output valid is not low %s", when));
      end
   endtask

   // ready levels held for random stretches
   task automatic drive_ready_pattern();
      forever begin
         @(posedge aclk);
         #1;
         if (random_ready) begin
            if (data_hold == 0) begin
               tx_data_ready = ($urandom_range(0, 9) < 6);
               data_hold     = $urandom_range(1, 8);
            end else begin
               data_hold--;
            end
            if (meta_hold == 0) begin
               tx_meta_ready = ($urandom_range(0, 9) < 6);
               meta_hold     = $urandom_range(1, 8);
            end else begin
               meta_hold--;
            end
         end else begin
            tx_data_ready = 1'b1;
            tx_meta_ready = 1'b1;
         end
      end
   endtask

   // ----------------------------------------------------------
   // output monitors
   // ----------------------------------------------------------
   always @(posedge aclk) begin
      if (aresetn && tx_data_valid && tx_data_ready) begin
         if (exp_beats.size() == 0) begin
            beat_errs++;
            report_problem("a transmit beat arrived when none was expected");
         end else begin
            check_beat(data_test, exp_beats.pop_front(), tx_data);
         end
      end
      if (aresetn && tx_meta_valid && tx_meta_ready) begin
         if (exp_metas.size() == 0) begin
            meta_errs++;
            report_problem("a metadata word arrived when none was expected");
         end else begin
            check_meta(meta_test, exp_metas.pop_front(), tx_meta);
         end
      end
      if (aresetn) begin
         if (listen_port_valid) begin
            if (port_prev) begin
               port_errs++;
               report_problem("listen port pulse is longer than one cycle");
            end
            if (port_idx < PORT_COUNT) begin
               check_port("port_sequence", port_t'(FIRST_PORT + port_idx), listen_port);
            end else begin
               port_errs++;
               report_problem("listen port pulse after the last port");
            end
            port_idx++;
         end
         port_prev = listen_port_valid;
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge aclk);
      $display("ERROR: run timed out after %0d cycles", WATCHDOG_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   // ----------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------
   initial begin
      int b0;
      int m0;
      void'($urandom(11));
      aresetn           = 1'b0;
      resp_valid        = 1'b0;
      resp_beat         = '0;
      tx_data_ready     = 1'b1;
      tx_meta_ready     = 1'b1;
      listen_port_ready = 1'b1;
      random_ready      = 1'b0;
      data_test         = "data_passthrough";
      meta_test         = "metadata_words";

      // ready generator draws from the same seeded stream
      fork
         drive_ready_pattern();
      join_none

      repeat (2) @(posedge aclk);
      check_idle("during reset");
      #1 aresetn = 1'b1;
      @(posedge aclk);
      check_idle("on the first cycle after reset");
      report_test("reset_state", other_errs);
      #1;

      // full ready
      b0 = beat_errs;
      m0 = meta_errs;
      repeat (PHASE1) add_response();
      drive_responses();
      wait_drained();
      report_test("data_passthrough", beat_errs - b0);
      report_test("metadata_words", meta_errs - m0);

      // random back-pressure on both outputs
      data_test    = "backpressure";
      meta_test    = "backpressure";
      b0           = beat_errs;
      m0           = meta_errs;
      random_ready = 1'b1;
      repeat (PHASE2) add_response();
      drive_responses();
      wait_drained();
      random_ready = 1'b0;
      // extra entries would show up here
      repeat (20) @(posedge aclk);
      report_test("backpressure", (beat_errs - b0) + (meta_errs - m0));

      if (port_idx != PORT_COUNT) begin
         port_errs++;
         report_problem($sformatf("saw %0d listen port pulses instead of %0d",
                                  port_idx, PORT_COUNT));
      end
      report_test("port_sequence", port_errs);

      $display("checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== files.f ====
+incdir+.
kvs_pkg.sv
net_pkg.sv
stream_fifo.sv
listen_port_opener.sv
response_framer.sv
kvs_net_egress.sv
tb_kvs_net_egress.sv

// ==== Bender.yml ====
package:
  name: kvs_net_egress

sources:
  - files:
      - kvs_pkg.sv
      - net_pkg.sv
      - stream_fifo.sv
      - listen_port_opener.sv
      - response_framer.sv
      - kvs_net_egress.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_kvs_net_egress.sv
